//--- wb_subsys.f
src/wb_pkg.sv
src/wb_master.sv
src/wb_decoder.sv
src/wb_data_mem.sv
src/wb_dev_regs.sv
src/wb_subsys.sv
test/wb_subsys_chk.sv
test/wb_subsys_tb.sv

//--- test/wb_subsys_tb.sv
// testbench for the bus subsystem: random command stream checked against a shadow model
`timescale 1ns/1ns

module wb_subsys_tb;

    logic          clk;
    logic          rst;
    wb_pkg::word_t cmd_addr;
    wb_pkg::cmd_t  cmd_word;
    logic          busy;
    wb_pkg::word_t rdata;
    logic          rdata_valid;

    wb_pkg::word_t mem_model [wb_pkg::MEM_WORDS];
    wb_pkg::word_t dev_model [wb_pkg::DEV_COUNT][wb_pkg::DEV_REGS];
    wb_pkg::word_t exp_q [$];  // expected read data, oldest first
    int            order [wb_pkg::MEM_WORDS];
    int            rdata_errs = 0;
    int            busy_errs = 0;
    int            valid_errs = 0;
    int            timeout_errs = 0;

    wb_subsys u_dut (
        .clk_i             (clk),
        .rst_i             (rst),
        .cmd_addr_i        (cmd_addr),
        .cmd_word_i        (cmd_word),
        .cmd_busy_o        (busy),
        .cmd_rdata_o       (rdata),
        .cmd_rdata_valid_o (rdata_valid)
    );

    always #5 clk = ~clk;

    // reference: bit 29 picks the region, 9:2 the memory word, 17:16 and 3:2 the device register
    function automatic wb_pkg::word_t expected_read(wb_pkg::word_t addr);
        if (addr[29]) begin
            return dev_model[addr[17:16]][addr[3:2]];
        end
        return mem_model[addr[9:2]];
    endfunction

    task automatic model_write(input wb_pkg::word_t addr, input wb_pkg::word_t data);
        if (addr[29]) begin
            dev_model[addr[17:16]][addr[3:2]] = data;
        end else begin
            mem_model[addr[9:2]] = data;
        end
    endtask

    function automatic wb_pkg::word_t mem_addr(int idx);
        wb_pkg::word_t a;
        a = $urandom();  // upper and byte bits are don't care
        a[29] = 1'b0;
        a[9:2] = idx[7:0];
        return a;
    endfunction

    function automatic wb_pkg::word_t dev_addr(int dev, int rg);
        wb_pkg::word_t a;
        a = $urandom();
        a[29] = 1'b1;
        a[17:16] = dev[1:0];
        a[3:2] = rg[1:0];
        return a;
    endfunction

    task automatic check_rdata(input wb_pkg::word_t got, input wb_pkg::word_t exp);
        if (got !== exp) begin
            rdata_errs++;
            $display("Error: cmd_rdata_o got %h expected %h", got, exp);
        end
    endtask

    task automatic check_busy(input logic got, input logic exp);
        if (got !== exp) begin
            busy_errs++;
            $display("Error: cmd_busy_o got %h expected %h", got, exp);
        end
    endtask

    task automatic check_valid(input logic got, input logic exp);
        if (got !== exp) begin
            valid_errs++;
            $display("Error: cmd_rdata_valid_o got %h expected %h", got, exp);
        end
    endtask

    task automatic finish_run();
        int assert_errs;
        assert_errs = u_dut.u_master.u_chk.fail_cnt;
        $display("errors: rdata %0d busy %0d valid %0d timeout %0d assert %0d",
                 rdata_errs, busy_errs, valid_errs, timeout_errs, assert_errs);
        if (rdata_errs + busy_errs + valid_errs + timeout_errs + assert_errs == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while (busy !== 1'b0 && n < 50) begin
            @(negedge clk);
            n++;
        end
        if (busy !== 1'b0) begin
            timeout_errs++;
            $display("timeout: busy never went low before a new command");
        end
    endtask

    // one accepted command, optionally followed by a write that lands while busy
    task automatic issue_cmd(input wb_pkg::word_t addr, input bit wr, input wb_pkg::word_t data,
                             input bit drop_next, input wb_pkg::word_t drop_data);
        wait_idle();
        cmd_addr = addr;
        cmd_word.wr = wr;
        cmd_word.rd = !wr;
        cmd_word.wdata = data;
        if (wr) begin
            model_write(addr, data);
        end else begin
            exp_q.push_back(expected_read(addr));
        end
        @(negedge clk);
        check_busy(busy, 1'b1);
        if (drop_next) begin
            cmd_word.wr = 1'b1;  // must be ignored
            cmd_word.rd = 1'b0;
            cmd_word.wdata = drop_data;
        end else begin
            cmd_word = '0;
        end
        @(negedge clk);
        check_busy(busy, 1'b1);
        cmd_word = '0;
        @(negedge clk);
        check_busy(busy, 1'b0);
        check_valid(rdata_valid, !wr);
    endtask

    task automatic write_word(input wb_pkg::word_t addr, input wb_pkg::word_t data);
        issue_cmd(addr, 1'b1, data, 1'b0, '0);
    endtask

    task automatic read_word(input wb_pkg::word_t addr);
        issue_cmd(addr, 1'b0, '0, 1'b0, '0);
    endtask

    // compare process, one pop per valid pulse
    always @(negedge clk) begin
        if (rst && rdata_valid) begin
            if (exp_q.size() == 0) begin
                valid_errs++;
                $display("read data valid with no read pending");
            end else begin
                check_rdata(rdata, exp_q.pop_front());
            end
        end
    end

    initial begin
        int j;
        int tmp;
        int n;
        wb_pkg::word_t a;
        clk = 1'b0;
        rst = 1'b0;
        cmd_addr = '0;
        cmd_word = '0;
        void'($urandom(88));
        for (int d = 0; d < wb_pkg::DEV_COUNT; d++) begin
            for (int r = 0; r < wb_pkg::DEV_REGS; r++) begin
                dev_model[d][r] = '0;
            end
        end
        repeat (10) @(negedge clk);
        rst = 1'b1;
        @(negedge clk);

        // device registers come up zero
        for (int d = 0; d < wb_pkg::DEV_COUNT; d++) begin
            for (int r = 0; r < wb_pkg::DEV_REGS; r++) begin
                read_word(dev_addr(d, r));
            end
        end

        // every memory word, in shuffled order
        for (int i = 0; i < wb_pkg::MEM_WORDS; i++) begin
            order[i] = i;
        end
        for (int i = wb_pkg::MEM_WORDS - 1; i > 0; i--) begin
            j = $urandom_range(i, 0);
            tmp = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        for (int i = 0; i < wb_pkg::MEM_WORDS; i++) begin
            write_word(mem_addr(order[i]), $urandom());
            read_word(mem_addr(order[i]));
        end

        // each device write, then the same register in all banks
        for (int d = 0; d < wb_pkg::DEV_COUNT; d++) begin
            for (int r = 0; r < wb_pkg::DEV_REGS; r++) begin
                write_word(dev_addr(d, r), $urandom());
                for (int k = 0; k < wb_pkg::DEV_COUNT; k++) begin
                    read_word(dev_addr(k, r));
                end
            end
        end

        // writes given while busy are dropped
        a = mem_addr($urandom_range(255, 0));
        issue_cmd(a, 1'b1, $urandom(), 1'b1, $urandom());
        read_word(a);
        a = dev_addr($urandom_range(3, 0), $urandom_range(3, 0));
        issue_cmd(a, 1'b1, $urandom(), 1'b1, $urandom());
        read_word(a);

        // random mix over both regions
        for (int i = 0; i < 300; i++) begin
            if ($urandom_range(1, 0)) begin
                a = dev_addr($urandom_range(3, 0), $urandom_range(3, 0));
            end else begin
                a = mem_addr($urandom_range(255, 0));
            end
            if ($urandom_range(1, 0)) begin
                write_word(a, $urandom());
            end else begin
                read_word(a);
            end
        end

        n = 0;
        while (exp_q.size() != 0 && n < 50) begin
            @(negedge clk);
            n++;
        end
        if (exp_q.size() != 0) begin
            timeout_errs++;
            $display("timeout: %0d reads never returned data", exp_q.size());
        end
        repeat (3) @(negedge clk);
        finish_run();
    end

endmodule

//--- test/wb_subsys_chk.sv
// protocol assertions on the bus master side, bound into wb_master by the bind at the bottom
`timescale 1ns/1ns

module wb_subsys_chk (
    input logic            clk_i,
    input logic            rst_i,
    input wb_pkg::wb_req_t bus_req_i,
    input wb_pkg::wb_rsp_t bus_rsp_i,
    input logic            rdata_valid_i
);

    int fail_cnt = 0;  // read by the testbench at the end of the run

    ap_stb_single: assert property (@(posedge clk_i) disable iff (!rst_i)
        bus_req_i.stb |=> !bus_req_i.stb)
        else begin
            fail_cnt++;
            $error("stb stayed high for more than one cycle");
        end

    ap_stb_in_cyc: assert property (@(posedge clk_i) disable iff (!rst_i)
        bus_req_i.stb |-> bus_req_i.cyc)
        else begin
            fail_cnt++;
            $error("stb high while cyc is low");
        end

    ap_valid_pulse: assert property (@(posedge clk_i) disable iff (!rst_i)
        rdata_valid_i |=> !rdata_valid_i)
        else begin
            fail_cnt++;
            $error("read data valid longer than one cycle");
        end

    // the ack that ends a cycle is seen one edge before cyc drops
    ap_cyc_end: assert property (@(posedge clk_i) disable iff (!rst_i)
        $fell(bus_req_i.cyc) |-> $past(bus_rsp_i.ack))
        else begin
            fail_cnt++;
            $error("cyc fell without an ack in the cycle before");
        end

endmodule

bind wb_master wb_subsys_chk u_chk (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .bus_req_i     (bus_req_o),
    .bus_rsp_i     (bus_rsp_i),
    .rdata_valid_i (cmd_rdata_valid_o)
);

//--- src/wb_subsys.sv
// subsystem top: cpu command port feeding the master, decoder, data memory and device block
`timescale 1ns/1ns

module wb_subsys (
    input  logic          clk_i,
    input  logic          rst_i,
    input  wb_pkg::word_t cmd_addr_i,
    input  wb_pkg::cmd_t  cmd_word_i,
    output logic          cmd_busy_o,
    output wb_pkg::word_t cmd_rdata_o,
    output logic          cmd_rdata_valid_o
);

    wb_pkg::wb_req_t bus_req;
    wb_pkg::wb_rsp_t bus_rsp;
    wb_pkg::wb_rsp_t mem_rsp;
    wb_pkg::wb_rsp_t dev_rsp;
    logic            mem_cyc;
    logic            dev_cyc;

    wb_master u_master (
        .clk_i             (clk_i),
        .rst_i             (rst_i),
        .cmd_addr_i        (cmd_addr_i),
        .cmd_word_i        (cmd_word_i),
        .cmd_busy_o        (cmd_busy_o),
        .cmd_rdata_o       (cmd_rdata_o),
        .cmd_rdata_valid_o (cmd_rdata_valid_o),
        .bus_req_o         (bus_req),
        .bus_rsp_i         (bus_rsp)
    );

    wb_decoder u_decoder (
        .bus_req_i (bus_req),
        .mem_cyc_o (mem_cyc),
        .dev_cyc_o (dev_cyc),
        .mem_rsp_i (mem_rsp),
        .dev_rsp_i (dev_rsp),
        .bus_rsp_o (bus_rsp)
    );

    wb_data_mem u_mem (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .bus_req_i (bus_req),
        .cyc_i     (mem_cyc),
        .bus_rsp_o (mem_rsp)
    );

    wb_dev_regs u_dev (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .bus_req_i (bus_req),
        .cyc_i     (dev_cyc),
        .bus_rsp_o (dev_rsp)
    );

endmodule

//--- src/wb_dev_regs.sv
// peripheral block: four banks of four registers, bank chosen by sel, register by address bits 3:2
`timescale 1ns/1ns

module wb_dev_regs (
    input  logic            clk_i,
    input  logic            rst_i,
    input  wb_pkg::wb_req_t bus_req_i,
    input  logic            cyc_i,
    output wb_pkg::wb_rsp_t bus_rsp_o
);

    wb_pkg::word_t regs [wb_pkg::DEV_COUNT][wb_pkg::DEV_REGS];
    wb_pkg::addr_u adr;
    wb_pkg::word_t rd_word;
    wb_pkg::word_t dat_q;
    logic          tgd_q;
    logic          ack_q;
    logic          access;
    logic          wr_ok;

    assign adr     = bus_req_i.adr;
    assign access  = cyc_i && bus_req_i.stb;
    assign rd_word = regs[bus_req_i.sel][adr.dev.reg_idx];

    assign wr_ok = access && bus_req_i.we
                 && (bus_req_i.tgd == wb_pkg::parity(bus_req_i.dat));

    // registers read zero until written
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            for (int d = 0; d < wb_pkg::DEV_COUNT; d++) begin
                for (int r = 0; r < wb_pkg::DEV_REGS; r++) begin
                    regs[d][r] <= '0;
                end
            end
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
            if (wr_ok) begin
                regs[bus_req_i.sel][adr.dev.reg_idx] <= bus_req_i.dat;
            end
        end
    end

    // response word, write data echoed back on writes
    always_ff @(posedge clk_i) begin
        if (access) begin
            if (bus_req_i.we) begin
                dat_q <= bus_req_i.dat;
                tgd_q <= wb_pkg::parity(bus_req_i.dat);
            end else begin
                dat_q <= rd_word;
                tgd_q <= wb_pkg::parity(rd_word);
            end
        end
    end

    always_comb begin
        bus_rsp_o.dat = dat_q;
        bus_rsp_o.ack = ack_q;
        bus_rsp_o.tgd = tgd_q;
    end

endmodule

//--- src/wb_data_mem.sv
// data memory slave: 256 full words, registered ack one cycle after stb, parity-checked writes
`timescale 1ns/1ns

module wb_data_mem (
    input  logic            clk_i,
    input  logic            rst_i,
    input  wb_pkg::wb_req_t bus_req_i,
    input  logic            cyc_i,
    output wb_pkg::wb_rsp_t bus_rsp_o
);

    wb_pkg::word_t mem [wb_pkg::MEM_WORDS];
    wb_pkg::addr_u adr;
    wb_pkg::word_t dat_q;
    logic          tgd_q;
    logic          ack_q;
    logic          access;
    logic          wr_ok;

    assign adr    = bus_req_i.adr;
    assign access = cyc_i && bus_req_i.stb;

    // store only when the write tag checks out
    assign wr_ok = access && bus_req_i.we
                 && (bus_req_i.tgd == wb_pkg::parity(bus_req_i.dat));

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;  // every access gets its ack
        end
    end

    always_ff @(posedge clk_i) begin
        if (wr_ok) begin
            mem[adr.mem.word_idx] <= bus_req_i.dat;
        end
        if (access) begin
            // writes echo their data so the returned tag is always defined
            if (bus_req_i.we) begin
                dat_q <= bus_req_i.dat;
                tgd_q <= wb_pkg::parity(bus_req_i.dat);
            end else begin
                dat_q <= mem[adr.mem.word_idx];
                tgd_q <= wb_pkg::parity(mem[adr.mem.word_idx]);
            end
        end
    end

    always_comb begin
        bus_rsp_o.dat = dat_q;
        bus_rsp_o.ack = ack_q;
        bus_rsp_o.tgd = tgd_q;
    end

endmodule

//--- src/wb_decoder.sv
// address decoder: steers the master's cycle to memory or devices by bit 29 and muxes responses
`timescale 1ns/1ns

module wb_decoder (
    input  wb_pkg::wb_req_t bus_req_i,
    output logic            mem_cyc_o,
    output logic            dev_cyc_o,
    input  wb_pkg::wb_rsp_t mem_rsp_i,
    input  wb_pkg::wb_rsp_t dev_rsp_i,
    output wb_pkg::wb_rsp_t bus_rsp_o
);

    wb_pkg::addr_u adr;
    logic          dev_sel;

    assign adr     = bus_req_i.adr;
    assign dev_sel = adr.dev.region;

    // exactly one slave sees cyc
    assign mem_cyc_o = bus_req_i.cyc && !adr.mem.region;
    assign dev_cyc_o = bus_req_i.cyc && dev_sel;

    always_comb begin
        bus_rsp_o = dev_sel ? dev_rsp_i : mem_rsp_i;
        if (!bus_req_i.cyc) begin
            bus_rsp_o.ack = 1'b0;  // no stray ack outside a cycle
        end
    end

endmodule

//--- src/wb_master.sv
// bus master: turns one-cycle cpu command strobes into single classic wishbone cycles
`timescale 1ns/1ns

module wb_master (
    input  logic            clk_i,
    input  logic            rst_i,
    input  wb_pkg::word_t   cmd_addr_i,
    input  wb_pkg::cmd_t    cmd_word_i,
    output logic            cmd_busy_o,
    output wb_pkg::word_t   cmd_rdata_o,
    output logic            cmd_rdata_valid_o,
    output wb_pkg::wb_req_t bus_req_o,
    input  wb_pkg::wb_rsp_t bus_rsp_i
);

    wb_pkg::addr_u cmd_addr;
    wb_pkg::word_t adr_q;
    wb_pkg::word_t dat_q;
    logic          we_q;
    logic          cyc_q;
    logic          stb_q;
    logic          rd_q;    // current cycle is a read
    logic [1:0]    sel_q;
    logic [1:0]    sel_d;
    logic          idle;
    logic          start;
    logic          rsp_ok;
    logic          done;

    assign cmd_addr = cmd_addr_i;

    assign idle  = !cyc_q && !stb_q;
    assign start = idle && (cmd_word_i.wr || cmd_word_i.rd);  // dropped while busy

    // device cycles select a bank, everything else uses the memory code
    assign sel_d = cmd_addr.dev.region ? cmd_addr.dev.dev_idx : wb_pkg::SEL_MEM;

    // bad tag means no completion, cyc just stays up
    assign rsp_ok = bus_rsp_i.ack && (bus_rsp_i.tgd == wb_pkg::parity(bus_rsp_i.dat));
    assign done   = cyc_q && !stb_q && rsp_ok;

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            cyc_q             <= 1'b0;
            stb_q             <= 1'b0;
            we_q              <= 1'b0;
            rd_q              <= 1'b0;
            sel_q             <= 2'b00;
            cmd_rdata_valid_o <= 1'b0;
        end else begin
            stb_q             <= start;  // one cycle only
            cmd_rdata_valid_o <= done && rd_q;
            if (start) begin
                cyc_q <= 1'b1;
                we_q  <= cmd_word_i.wr && !cmd_word_i.rd;  // read wins if both set
                rd_q  <= cmd_word_i.rd;
                sel_q <= sel_d;
            end else if (done) begin
                cyc_q <= 1'b0;
                we_q  <= 1'b0;
                rd_q  <= 1'b0;
                sel_q <= wb_pkg::SEL_MEM;
            end
        end
    end

    // address and data stay put for the whole cycle so the decoder keeps its route
    always_ff @(posedge clk_i) begin
        if (start) begin
            adr_q <= cmd_addr_i;
            dat_q <= cmd_word_i.wdata;
        end
        if (done && rd_q) begin
            cmd_rdata_o <= bus_rsp_i.dat;
        end
    end

    always_comb begin
        bus_req_o.adr = adr_q;
        bus_req_o.dat = dat_q;
        bus_req_o.we  = we_q;
        bus_req_o.cyc = cyc_q;
        bus_req_o.stb = stb_q;
        bus_req_o.sel = sel_q;
        bus_req_o.tgd = wb_pkg::parity(dat_q);
    end

    assign cmd_busy_o = cyc_q || stb_q;

endmodule

//--- src/wb_pkg.sv
// shared bus types, address views and sizes for the wishbone subsystem; referenced by scoped name
package wb_pkg;

    localparam int MEM_WORDS = 256;  // data memory depth in words
    localparam int DEV_COUNT = 4;    // peripheral banks behind the device region
    localparam int DEV_REGS  = 4;    // registers per bank

    localparam logic [1:0] SEL_MEM = 2'b11;  // select for memory and idle cycles

    typedef logic [31:0] word_t;

    // cpu command word, bit 33 write, bit 32 read
    typedef struct packed {
        logic  wr;
        logic  rd;
        word_t wdata;
    } cmd_t;

    // memory region view of an address
    typedef struct packed {
        logic [1:0]  rsv_hi;
        logic        region;    // bit 29, clear for memory
        logic [18:0] rsv_mid;
        logic [7:0]  word_idx;  // bits 9:2
        logic [1:0]  byte_off;
    } mem_view_t;

    // device region view of the same address
    typedef struct packed {
        logic [1:0]  rsv_hi;
        logic        region;    // bit 29, set for devices
        logic [10:0] rsv_mid;
        logic [1:0]  dev_idx;   // bits 17:16
        logic [11:0] rsv_lo;
        logic [1:0]  reg_idx;   // bits 3:2
        logic [1:0]  byte_off;
    } dev_view_t;

    typedef union packed {
        mem_view_t mem;
        dev_view_t dev;
    } addr_u;

    // master to slave
    typedef struct packed {
        word_t      adr;
        word_t      dat;
        logic       we;
        logic       cyc;
        logic       stb;
        logic [1:0] sel;
        logic       tgd;  // even parity of dat
    } wb_req_t;

    // slave to master
    typedef struct packed {
        word_t dat;
        logic  ack;
        logic  tgd;  // even parity of dat
    } wb_rsp_t;

    // even parity tag for a bus word
    function automatic logic parity(word_t w);
        return ^w;
    endfunction

endpackage
